/* hw/xif_tile_pkg.sv */
// Geometry and reset rules for a three coprocessor tile that routes by the major opcode only
package xif_tile_pkg;

  localparam int unsigned N_COPROC    = 3;  // Coprocessors behind the demux
  localparam int unsigned N_OPCODE    = 2;  // Opcode slots held per coprocessor
  localparam int unsigned DEFAULT_IDX = 0;  // Target for opcodes that match no rule

  localparam int unsigned OPCODE_OFF = 0;  // LSB of the major opcode in the instruction
  localparam int unsigned OPCODE_W   = 7;  // Width of the major opcode

  localparam int unsigned XIF_ID_W = 4;  // Instruction id width on the issue channel

  localparam int unsigned AXI_ADDR_W = 8;                 // Config bus address width
  localparam int unsigned AXI_DATA_W = 32;                // Config bus data width
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;    // One strobe bit per byte
  localparam int unsigned AXI_WORD_W = AXI_ADDR_W - 2;    // Word index bits above the byte offset

  localparam int unsigned DRAIN_GAP = 3;                      // Cycles a queue head waits
  localparam int unsigned GAP_W     = $clog2(DRAIN_GAP + 1);  // Gap counter width

  localparam int unsigned RULE_W = N_COPROC * N_OPCODE * OPCODE_W;  // Flat table width

  typedef logic [31:0]             instr_t;       // Full instruction word
  typedef logic [OPCODE_W-1:0]     opcode_t;      // Major opcode field
  typedef logic [XIF_ID_W-1:0]     xif_id_t;      // Issue id
  typedef logic [RULE_W-1:0]       rule_tbl_t;    // Entry i*N_OPCODE+j is coprocessor i slot j
  typedef logic [N_COPROC-1:0]     coproc_sel_t;  // One bit per coprocessor
  typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;    // Config bus address
  typedef logic [AXI_DATA_W-1:0]   axi_data_t;    // Config bus data
  typedef logic [AXI_STRB_W-1:0]   axi_strb_t;    // Config bus write strobes
  typedef logic [AXI_WORD_W-1:0]   axi_word_t;    // Register index

  // Reset table listed from the top entry down to entry 0
  localparam rule_tbl_t RULE_RST = {
    opcode_t'(7'h7B),  // Coprocessor 2 slot 1
    opcode_t'(7'h5B),  // Coprocessor 2 slot 0
    opcode_t'(7'h2B),  // Coprocessor 1 slot 1
    opcode_t'(7'h0B),  // Coprocessor 1 slot 0
    opcode_t'(7'h7F),  // Coprocessor 0 slot 1 holds an opcode that is never issued
    opcode_t'(7'h7F)   // Coprocessor 0 slot 0 so it only ever takes the default
  };

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;  // Normal access
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;  // Bad address or partial write

  // Retire stage of each coprocessor queue
  typedef enum logic [1:0] {
    IDLE,    // Nothing at the head
    WAIT,    // Head is counting down its service gap
    RETIRE   // Head leaves with a one cycle pulse
  } queue_state_e;

endpackage : xif_tile_pkg

/* hw/xif_issue_if.sv */
// Issue channel subset of the extension interface without commit memory or result traffic
interface xif_issue_if
  import xif_tile_pkg::*;
();

  logic    issue_valid;  // Core offers an instruction
  logic    issue_ready;  // Coprocessor side can take it
  instr_t  instr;        // Offered instruction word
  xif_id_t id;           // Id that comes back on retire
  logic    accept;       // Coprocessor will execute it
  logic    writeback;    // Coprocessor will write a register

  // Core side drives the request and sees the response
  modport core (
    output issue_valid,
    output instr,
    output id,
    input  issue_ready,
    input  accept,
    input  writeback
  );

  // Coprocessor side mirrors the core
  modport coproc (
    input  issue_valid,
    input  instr,
    input  id,
    output issue_ready,
    output accept,
    output writeback
  );

endinterface : xif_issue_if

/* hw/xif_rule_regs.sv */
// Single outstanding AXI4-Lite slave where partial writes and addresses past the table get SLVERR
module xif_rule_regs
  import xif_tile_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       s_axi_awvalid_i,
  output logic       s_axi_awready_o,
  input  axi_addr_t  s_axi_awaddr_i,
  input  logic       s_axi_wvalid_i,
  output logic       s_axi_wready_o,
  input  axi_data_t  s_axi_wdata_i,
  input  axi_strb_t  s_axi_wstrb_i,
  output logic       s_axi_bvalid_o,
  input  logic       s_axi_bready_i,
  output logic [1:0] s_axi_bresp_o,
  input  logic       s_axi_arvalid_i,
  output logic       s_axi_arready_o,
  input  axi_addr_t  s_axi_araddr_i,
  output logic       s_axi_rvalid_o,
  input  logic       s_axi_rready_i,
  output axi_data_t  s_axi_rdata_o,
  output logic [1:0] s_axi_rresp_o,
  output rule_tbl_t  rule_tbl_o
);

  rule_tbl_t  rule_tbl_q;    // Live routing table
  logic       bvalid_q;      // Write response pending
  logic       rvalid_q;      // Read response pending
  logic [1:0] bresp_q;       // Stored write response code
  logic [1:0] rresp_q;       // Stored read response code
  axi_data_t  rdata_q;       // Stored read data
  logic       wr_hs;         // Address and data taken together
  logic       rd_hs;         // Read address taken
  logic       wr_err;        // Write is refused
  logic       rd_err;        // Read is refused
  axi_word_t  wr_word;       // Register index of the write
  axi_word_t  rd_word;       // Register index of the read
  axi_data_t  rd_word_data;  // Packed view of the addressed register

  assign wr_word = s_axi_awaddr_i[AXI_ADDR_W-1:2];  // Byte offset is ignored
  assign rd_word = s_axi_araddr_i[AXI_ADDR_W-1:2];  // Same decode for reads

  assign wr_err = (s_axi_awaddr_i >= axi_addr_t'(4 * N_COPROC))
                | (s_axi_wstrb_i != '1);  // Only full word writes land
  assign rd_err = s_axi_araddr_i >= axi_addr_t'(4 * N_COPROC);  // Past the last register

  // Both channels are taken in one cycle and only while no response is pending
  assign s_axi_awready_o = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q;
  assign s_axi_wready_o  = s_axi_awready_o;  // Address and data rise together
  assign wr_hs           = s_axi_awready_o;  // Ready already implies both valids

  assign s_axi_arready_o = ~rvalid_q;                   // Free while no read data waits
  assign rd_hs           = s_axi_arvalid_i & ~rvalid_q;  // Address accepted this cycle

  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = bresp_q;
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rresp_o  = rresp_q;
  assign s_axi_rdata_o  = rdata_q;
  assign rule_tbl_o     = rule_tbl_q;  // New rules act from the cycle after the write

  // Slot j of a register sits in byte j with the upper bit of the byte zero
  always_comb begin
    rd_word_data = '0;
    for (int i = 0; i < N_COPROC; i++) begin
      if (rd_word == axi_word_t'(i)) begin
        for (int j = 0; j < N_OPCODE; j++) begin
          rd_word_data[j*8 +: OPCODE_W] = rule_tbl_q[(i*N_OPCODE+j)*OPCODE_W +: OPCODE_W];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rule_tbl_q <= RULE_RST;  // Default routing after reset
    end else if (wr_hs && !wr_err) begin
      for (int i = 0; i < N_COPROC; i++) begin
        if (wr_word == axi_word_t'(i)) begin
          for (int j = 0; j < N_OPCODE; j++) begin
            rule_tbl_q[(i*N_OPCODE+j)*OPCODE_W +: OPCODE_W] <= s_axi_wdata_i[j*8 +: OPCODE_W];
          end
        end
      end
    end
  end

  // Response valids hold until the master takes them
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;  // Response one cycle after the handshake
      end else if (s_axi_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;  // Data one cycle after the address
      end else if (s_axi_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      bresp_q <= wr_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    end
    if (rd_hs) begin
      rresp_q <= rd_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
      rdata_q <= rd_err ? '0 : rd_word_data;  // Refused reads return zero
    end
  end

endmodule : xif_rule_regs

/* hw/xif_inst_demux.sv */
// Purely combinational router so ready and the response pass through in the same cycle
module xif_inst_demux
  import xif_tile_pkg::*;
(
  xif_issue_if.coproc issue_if_i,            // From the core
  xif_issue_if.core   issue_if_o [N_COPROC],  // Toward each coprocessor queue
  input rule_tbl_t    rule_tbl_i             // Live routing table
);

  opcode_t     opcode;         // Major opcode of the offered instruction
  coproc_sel_t opcode_match;   // Coprocessors that list this opcode
  coproc_sel_t sel_raw;        // Matches or the default when nothing matched
  coproc_sel_t sel;            // One hot target after priority
  coproc_sel_t ready_vec;      // Ready from every queue
  coproc_sel_t accept_vec;     // Accept from every queue
  coproc_sel_t writeback_vec;  // Writeback from every queue

  assign opcode = issue_if_i.instr[OPCODE_OFF +: OPCODE_W];

  // Any slot of a coprocessor that holds the opcode makes it a candidate
  always_comb begin
    opcode_match = '0;
    for (int i = 0; i < N_COPROC; i++) begin
      for (int j = 0; j < N_OPCODE; j++) begin
        if (rule_tbl_i[(i*N_OPCODE+j)*OPCODE_W +: OPCODE_W] == opcode) begin
          opcode_match[i] = 1'b1;
        end
      end
    end
  end

  // Unmatched opcodes fall back to the default coprocessor
  assign sel_raw = (|opcode_match) ? opcode_match : (coproc_sel_t'(1) << DEFAULT_IDX);

  // Keep the lowest set bit so the lowest index wins a tie
  assign sel = sel_raw & (~sel_raw + coproc_sel_t'(1));

  for (genvar i = 0; i < N_COPROC; i++) begin : g_fwd
    // Unselected coprocessors see an idle channel with zero payload
    assign issue_if_o[i].issue_valid = issue_if_i.issue_valid & sel[i];
    assign issue_if_o[i].instr       = sel[i] ? issue_if_i.instr : '0;
    assign issue_if_o[i].id          = sel[i] ? issue_if_i.id : '0;

    assign ready_vec[i]     = issue_if_o[i].issue_ready;  // Gathered for the return mux
    assign accept_vec[i]    = issue_if_o[i].accept;
    assign writeback_vec[i] = issue_if_o[i].writeback;
  end

  // Select is one hot so an AND-OR reduction picks the single target
  assign issue_if_i.issue_ready = |(ready_vec & sel);
  assign issue_if_i.accept      = |(accept_vec & sel);
  assign issue_if_i.writeback   = |(writeback_vec & sel);

endmodule : xif_inst_demux

/* hw/xif_coproc_queue.sv */
// Ready comes from a flop so it is low in reset and funct3 of 3'b111 is rejected without storage
module xif_coproc_queue
  import xif_tile_pkg::*;
#(
  parameter int unsigned DEPTH = 4  // Ids the queue can hold
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  xif_issue_if.coproc issue_if_i,      // Routed issue channel
  output logic        retire_valid_o,  // One cycle pulse per retired id
  output xif_id_t     retire_id_o      // Id leaving the queue
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Slot index width
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);              // Fill level width

  xif_id_t          mem_q [DEPTH];  // Stored ids in issue order
  logic [PTR_W-1:0] wr_ptr_q;       // Next free slot
  logic [PTR_W-1:0] rd_ptr_q;       // Current head
  logic [CNT_W-1:0] cnt_q;          // Entries held
  logic [CNT_W-1:0] cnt_d;          // Entries after this edge
  logic             ready_q;        // Not full as seen this cycle
  logic             accept;         // Instruction is one we execute
  logic             push;           // Id enters the FIFO
  logic             pop;            // Head leaves the FIFO
  queue_state_e     state_q;        // Retire stage state
  queue_state_e     state_d;
  logic [GAP_W-1:0] gap_q;          // Remaining service gap of the head
  logic [GAP_W-1:0] gap_d;

  assign accept = issue_if_i.instr[14:12] != 3'b111;  // funct3 of all ones is not ours
  assign push   = issue_if_i.issue_valid & ready_q & accept;
  assign pop    = state_q == RETIRE;  // Retire pulse removes the head

  assign issue_if_i.issue_ready = ready_q;
  assign issue_if_i.accept      = accept;
  assign issue_if_i.writeback   = issue_if_i.instr[11:7] != 5'd0;  // Nonzero rd writes back

  assign retire_valid_o = state_q == RETIRE;
  assign retire_id_o    = mem_q[rd_ptr_q];  // Head id is only meaningful with the pulse

  always_comb begin
    cnt_d = cnt_q;
    if (push && !pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!push && pop) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  // Head spends DRAIN_GAP cycles in WAIT and then pulses in RETIRE
  always_comb begin
    state_d = state_q;
    gap_d   = gap_q;
    unique case (state_q)
      IDLE: begin
        if (cnt_d != '0) begin
          state_d = WAIT;  // A push into an empty queue is already at the head
          gap_d   = GAP_W'(DRAIN_GAP - 1);
        end
      end
      WAIT: begin
        if (gap_q == '0) begin
          state_d = RETIRE;
        end else begin
          gap_d = gap_q - 1'b1;
        end
      end
      RETIRE: begin
        if (cnt_d != '0) begin
          state_d = WAIT;  // Next entry moves up and starts its own gap
          gap_d   = GAP_W'(DRAIN_GAP - 1);
        end else begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      ready_q  <= 1'b0;  // Core is held off until reset ends
      state_q  <= IDLE;
      gap_q    <= '0;
    end else begin
      cnt_q   <= cnt_d;
      ready_q <= cnt_d != CNT_W'(DEPTH);  // Ready tracks not full
      state_q <= state_d;
      gap_q   <= gap_d;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= issue_if_i.id;
    end
  end

endmodule : xif_coproc_queue

/* hw/xif_tile_top.sv */
// Tile top with a single issue port and one retire port per coprocessor that each hold four ids
module xif_tile_top
  import xif_tile_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   issue_valid_i,
  output logic                   issue_ready_o,
  input  instr_t                 issue_instr_i,
  input  xif_id_t                issue_id_i,
  output logic                   issue_accept_o,
  output logic                   issue_writeback_o,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,
  input  axi_addr_t              s_axi_awaddr_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,
  input  axi_data_t              s_axi_wdata_i,
  input  axi_strb_t              s_axi_wstrb_i,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,
  output logic [1:0]             s_axi_bresp_o,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,
  input  axi_addr_t              s_axi_araddr_i,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i,
  output axi_data_t              s_axi_rdata_o,
  output logic [1:0]             s_axi_rresp_o,
  output coproc_sel_t            retire_valid_o,
  output xif_id_t [N_COPROC-1:0] retire_id_o
);

  rule_tbl_t rule_tbl;  // Table from the config registers to the router

  xif_issue_if core_if ();              // Core facing channel
  xif_issue_if coproc_if [N_COPROC] (); // One routed channel per queue

  assign core_if.issue_valid = issue_valid_i;  // Plain ports feed the core side
  assign core_if.instr       = issue_instr_i;
  assign core_if.id          = issue_id_i;
  assign issue_ready_o       = core_if.issue_ready;
  assign issue_accept_o      = core_if.accept;
  assign issue_writeback_o   = core_if.writeback;

  xif_rule_regs u_rule_regs (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .rule_tbl_o      (rule_tbl)
  );

  xif_inst_demux u_inst_demux (
    .issue_if_i (core_if),
    .issue_if_o (coproc_if),
    .rule_tbl_i (rule_tbl)
  );

  for (genvar i = 0; i < N_COPROC; i++) begin : q_gen
    xif_coproc_queue #(
      .DEPTH (4)  // Fifth back to back issue stalls the core
    ) u_queue (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .issue_if_i     (coproc_if[i]),
      .retire_valid_o (retire_valid_o[i]),
      .retire_id_o    (retire_id_o[i])
    );
  end

endmodule : xif_tile_top

/* tb/xif_tile_asserts.sv */
// Bound to the tile top and sampled on the rising clock with three queues wired in by the bind
module xif_tile_asserts
  import xif_tile_pkg::*;
(
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    issue_ready_i,   // Core facing ready
  input coproc_sel_t             route_valid_i,   // Valids the demux drives toward each queue
  input logic                    awready_i,
  input logic                    bvalid_i,
  input logic                    bready_i,
  input logic                    arready_i,
  input logic                    rvalid_i,
  input logic                    rready_i,
  input coproc_sel_t             retire_valid_i,  // Retire pulses at the top level
  input logic [N_COPROC-1:0][1:0] queue_state_i   // Retire stage state of each queue
);

  // Only one coprocessor may see an instruction at a time
  a_route_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(route_valid_i))
    else $error("Demux offers the instruction to more than one coprocessor");

  // Queues hold off the core while reset is applied
  a_ready_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !issue_ready_i)
    else $error("Issue ready is high during reset");

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("Write response dropped before the master took it");

  a_no_aw_while_b: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bvalid_i |-> !awready_i)
    else $error("New write address taken while a write response waits");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("Read data dropped before the master took it");

  a_no_ar_while_r: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i |-> !arready_i)
    else $error("New read address taken while read data waits");

  for (genvar i = 0; i < N_COPROC; i++) begin : g_retire
    // Each of the DRAIN_GAP cycles before a pulse is spent waiting
    for (genvar k = 1; k <= DRAIN_GAP; k++) begin : g_gap
      a_retire_gap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        retire_valid_i[i] |-> $past(queue_state_e'(queue_state_i[i]), k) == WAIT)
        else $error("Retire pulse came before the service gap ran out");
    end

    // The wait started exactly DRAIN_GAP cycles before the pulse
    a_retire_gap_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      retire_valid_i[i] |-> $past(queue_state_e'(queue_state_i[i]), DRAIN_GAP + 1) != WAIT)
      else $error("Queue head waited longer than the service gap");
  end

endmodule : xif_tile_asserts

/* tb/tb_xif_tile.sv */
// One issue in flight at a time with a reference rule table that only tracks full word AXI writes
module tb_xif_tile
  import xif_tile_pkg::*;
();

  localparam int unsigned TIMEOUT_CYC = 4000;  // About 30 issues and 10 AXI accesses need under 500

  logic                   clk;
  logic                   arst_n;
  logic                   issue_valid;
  logic                   issue_ready;
  instr_t                 issue_instr;
  xif_id_t                issue_id;
  logic                   issue_accept;
  logic                   issue_writeback;
  logic                   awvalid, awready, wvalid, wready, bvalid, bready;
  logic                   arvalid, arready, rvalid, rready;
  axi_addr_t              awaddr, araddr;
  axi_data_t              wdata, rdata;
  axi_strb_t              wstrb;
  logic [1:0]             bresp, rresp;
  coproc_sel_t            retire_valid;
  xif_id_t [N_COPROC-1:0] retire_id;

  logic [31:0] lcg_state;                      // Random source for opcodes ids and rd
  int unsigned cycle_cnt;                      // Rising edges since time zero
  opcode_t     rules [N_COPROC][N_OPCODE];     // Reference copy of the routing table
  xif_id_t     exp_ids [N_COPROC][$];          // Ids each coprocessor must retire in order
  logic        saw_stall;                      // Core was held off during an issue

  always #2 clk = ~clk;

  xif_tile_top dut0 (
    .clk_i (clk), .arst_n_i (arst_n),
    .issue_valid_i (issue_valid), .issue_ready_o (issue_ready),
    .issue_instr_i (issue_instr), .issue_id_i (issue_id),
    .issue_accept_o (issue_accept), .issue_writeback_o (issue_writeback),
    .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready), .s_axi_awaddr_i (awaddr),
    .s_axi_wvalid_i (wvalid), .s_axi_wready_o (wready), .s_axi_wdata_i (wdata),
    .s_axi_wstrb_i (wstrb), .s_axi_bvalid_o (bvalid), .s_axi_bready_i (bready),
    .s_axi_bresp_o (bresp), .s_axi_arvalid_i (arvalid), .s_axi_arready_o (arready),
    .s_axi_araddr_i (araddr), .s_axi_rvalid_o (rvalid), .s_axi_rready_i (rready),
    .s_axi_rdata_o (rdata), .s_axi_rresp_o (rresp),
    .retire_valid_o (retire_valid), .retire_id_o (retire_id)
  );

  // Concatenations list coprocessor 2 first so bit i belongs to coprocessor i
  bind xif_tile_top xif_tile_asserts u_asserts (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .issue_ready_i (issue_ready_o),
    .route_valid_i ({coproc_if[2].issue_valid, coproc_if[1].issue_valid,
                     coproc_if[0].issue_valid}),
    .awready_i (s_axi_awready_o), .bvalid_i (s_axi_bvalid_o), .bready_i (s_axi_bready_i),
    .arready_i (s_axi_arready_o), .rvalid_i (s_axi_rvalid_o), .rready_i (s_axi_rready_i),
    .retire_valid_i (retire_valid_o),
    .queue_state_i ({q_gen[2].u_queue.state_q, q_gen[1].u_queue.state_q,
                     q_gen[0].u_queue.state_q})
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
    return lcg_state;
  endfunction

  // Lowest coprocessor with a matching slot wins and no match goes to the default
  function automatic int route_of(opcode_t op);
    for (int i = 0; i < N_COPROC; i++) begin
      for (int j = 0; j < N_OPCODE; j++) begin
        if (rules[i][j] == op) return i;
      end
    end
    return int'(DEFAULT_IDX);
  endfunction

  function automatic logic in_table(opcode_t op);
    foreach (rules[i, j]) begin
      if (rules[i][j] == op) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic axi_data_t reg_image(int idx);
    axi_data_t img;
    img       = '0;
    img[6:0]  = rules[idx][0];  // Slot 0 in the low byte
    img[14:8] = rules[idx][1];  // Slot 1 in the next byte
    return img;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < N_COPROC; i++) begin
      n += exp_ids[i].size();
    end
    return n;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("Fail %s expected %0h actual %0h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Drives on the falling edge and samples the combinational response a quarter cycle later
  task automatic issue_one(input string name, input opcode_t op, input logic [4:0] rd,
                           input logic [2:0] funct3);
    logic [31:0] r;
    xif_id_t     id;
    int          cp;
    r  = lcg_next();
    id = xif_id_t'(lcg_next() >> 28);
    cp = route_of(op);
    @(negedge clk);
    issue_valid = 1'b1;
    issue_instr = {r[31:15], funct3, rd, op};
    issue_id    = id;
    #1;
    while (!issue_ready) begin
      saw_stall = 1'b1;  // Held instruction stays on the bus
      @(negedge clk);
      #1;
    end
    check_value({name, "_accept"}, 32'(funct3 != 3'b111), 32'(issue_accept));
    check_value({name, "_writeback"}, 32'(rd != 5'd0), 32'(issue_writeback));
    if (funct3 != 3'b111) begin
      exp_ids[cp].push_back(id);  // Rejected instructions never retire
    end
    @(posedge clk);  // Transfer edge
  endtask

  task automatic issue_rand(input string name, input opcode_t op);
    issue_one(name, op, 5'(lcg_next() >> 27), 3'(lcg_next() % 7));
  endtask

  task automatic issue_other(input string name);
    opcode_t op;
    op = opcode_t'(lcg_next() >> 25);
    while (in_table(op)) begin
      op = opcode_t'(lcg_next() >> 25);  // Keep only opcodes no rule lists
    end
    issue_rand(name, op);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    issue_valid = 1'b0;
    while (pending() != 0) begin
      @(negedge clk);
    end
    repeat (2 * DRAIN_GAP + 2) @(negedge clk);  // Quiet time exposes a stray retire
  endtask

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           output logic [1:0] resp);
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    check_value("axi_wready", 32'd1, 32'(wready));  // Data is taken in the address cycle
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(negedge clk);
    end
    @(negedge clk);  // Response waits a cycle before the master takes it
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data, output logic [1:0] resp);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) begin
      @(negedge clk);
    end
    @(negedge clk);  // Data also waits a cycle
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic program_rule(input string name, input int idx, input opcode_t slot0,
                              input opcode_t slot1);
    logic [1:0] resp;
    axi_write(axi_addr_t'(4 * idx), {17'd0, slot1, 1'b0, slot0}, 4'hF, resp);
    check_value({name, "_bresp"}, 32'(AXI_RESP_OKAY), 32'(resp));
    rules[idx][0] = slot0;
    rules[idx][1] = slot1;
  endtask

  task automatic read_check(input string name, input axi_addr_t addr, input axi_data_t exp_data,
                            input logic [1:0] exp_resp);
    axi_data_t  data;
    logic [1:0] resp;
    axi_read(addr, data, resp);
    check_value({name, "_rresp"}, 32'(exp_resp), 32'(resp));
    if (exp_resp == AXI_RESP_OKAY) begin
      check_value({name, "_rdata"}, exp_data, data);
    end
  endtask

  // Retire pulses last one cycle so the falling edge sees each exactly once
  always @(negedge clk) begin
    if (arst_n) begin
      for (int i = 0; i < N_COPROC; i++) begin
        if (retire_valid[i]) begin
          if (exp_ids[i].size() == 0) begin
            fail_now($sformatf("Coprocessor %0d retired id %0h with nothing expected",
                               i, retire_id[i]));
          end else begin
            check_value($sformatf("retire_cp%0d", i), 32'(exp_ids[i][0]), 32'(retire_id[i]));
            void'(exp_ids[i].pop_front());
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles with the tests still running", cycle_cnt);
      $display("Checks failed");
      $fatal(1, "Run did not finish in time");
    end
  end

  initial begin
    logic [1:0] resp;
    clk         = 1'b0;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_id    = '0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    lcg_state   = 32'h0731_d36f;
    cycle_cnt   = 0;
    saw_stall   = 1'b0;
    rules[0][0] = 7'h7F;  // Default coprocessor holds an opcode that is never issued
    rules[0][1] = 7'h7F;
    rules[1][0] = 7'h0B;
    rules[1][1] = 7'h2B;
    rules[2][0] = 7'h5B;
    rules[2][1] = 7'h7B;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    issue_rand("default_0b", 7'h0B);
    issue_rand("default_5b", 7'h5B);
    repeat (6) issue_other("default_other");
    wait_drain();

    program_rule("reprog_cp1", 1, 7'h6B, 7'h2B);  // Frees 0x0B from coprocessor 1
    program_rule("reprog_cp2", 2, 7'h0B, 7'h7B);
    read_check("reprog_read", 8'h08, reg_image(2), AXI_RESP_OKAY);
    repeat (4) issue_rand("reprog_0b", 7'h0B);
    wait_drain();

    program_rule("prio_cp2", 2, 7'h0B, 7'h2B);  // 0x2B now sits in coprocessors 1 and 2
    repeat (3) issue_rand("prio_2b", 7'h2B);
    wait_drain();

    issue_one("resp_reject", 7'h0B, 5'd3, 3'b111);
    issue_one("resp_rd0", 7'h0B, 5'd0, 3'b010);
    wait_drain();

    saw_stall = 1'b0;
    repeat (5) issue_rand("stall_2b", 7'h2B);  // One more than the queue holds
    check_value("stall_ready_low", 32'd1, 32'(saw_stall));
    wait_drain();

    axi_write(8'h20, 32'h0000_0B0B, 4'hF, resp);
    check_value("slverr_write", 32'(AXI_RESP_SLVERR), 32'(resp));
    axi_write(8'h00, 32'h0000_0B0B, 4'h3, resp);  // Partial write is refused too
    check_value("slverr_strobe", 32'(AXI_RESP_SLVERR), 32'(resp));
    read_check("slverr_read", 8'h20, '0, AXI_RESP_SLVERR);
    read_check("slverr_keep", 8'h00, reg_image(0), AXI_RESP_OKAY);
    issue_rand("slverr_0b", 7'h0B);
    issue_rand("slverr_2b", 7'h2B);
    issue_other("slverr_other");
    wait_drain();

    $display("All checks passed");
    $finish;
  end

endmodule : tb_xif_tile

/* flist.f */
hw/xif_tile_pkg.sv
hw/xif_issue_if.sv
hw/xif_rule_regs.sv
hw/xif_inst_demux.sv
hw/xif_coproc_queue.sv
hw/xif_tile_top.sv
tb/xif_tile_asserts.sv
tb/tb_xif_tile.sv

/* run.sh */
#!/bin/sh
# Build and run the tile testbench; the exit status is the simulator's
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_xif_tile -o tb_xif_tile
./obj_dir/tb_xif_tile
